//--- Bender.yml
package:
  name: fp_adder

dependencies: {}

sources:
  - verilog/fp_format_pkg.sv
  - verilog/fp_pipe_pkg.sv
  - verilog/fp_stage_if.sv
  - verilog/fp_decode.sv
  - verilog/fp_execute.sv
  - verilog/fp_normalize.sv
  - verilog/fp_result.sv
  - verilog/fp_adder.sv
  - target: test
    files:
      - verification/fp_adder_asserts.sv
      - verification/fp_adder_tb.sv

//--- files.f
verilog/fp_format_pkg.sv
verilog/fp_pipe_pkg.sv
verilog/fp_stage_if.sv
verilog/fp_decode.sv
verilog/fp_execute.sv
verilog/fp_normalize.sv
verilog/fp_result.sv
verilog/fp_adder.sv
verification/fp_adder_asserts.sv
verification/fp_adder_tb.sv

//--- verification/fp_adder_asserts.sv
`default_nettype none

module fp_adder_asserts
    import fp_format_pkg::*, fp_pipe_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      in_valid,
    input logic      in_ready,
    input logic      out_valid,
    input fp_word_t  result,
    input fp_flags_t flags
);
    int pending;
    int fail_count = 0;

    // Accepted inputs not yet returned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(in_valid && in_ready) - int'(out_valid);
        end
    end

    assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during reset");
        end

    assert property (@(posedge clk) $rose(rst_n) |-> (!out_valid && in_ready))
        else begin
            fail_count++;
            $error("pipeline not idle after reset");
        end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> (pending > 0))
        else begin
            fail_count++;
            $error("out_valid without an accepted input");
        end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> !$isunknown({result, flags}))
        else begin
            fail_count++;
            $error("unknown result or flags on out_valid");
        end

endmodule

`default_nettype wire

//--- verification/fp_adder_tb.sv
`default_nettype none

module fp_adder_tb
    import fp_format_pkg::*, fp_pipe_pkg::*;
();
    localparam int reset_cycles   = 8;
    localparam int n_rand         = 20;
    localparam int n_cancel       = 6;
    localparam int total_ops      = 2 * n_rand + n_cancel + 7 + 2 + 2;
    localparam int timeout_cycles = reset_cycles + 40 * total_ops;

    localparam fp_word_t pos_inf = 32'h7F80_0000;
    localparam fp_word_t neg_inf = 32'hFF80_0000;
    localparam fp_word_t max_fin = 32'h7F7F_FFFF;

    logic        clk = 1'b0;
    logic        rst_n;
    fp_word_t    op_a;
    fp_word_t    op_b;
    round_mode_t round_mode;
    logic        in_valid;
    logic        in_ready;
    fp_word_t    result;
    fp_flags_t   flags;
    logic        out_valid;

    fp_word_t    res_q[$];
    fp_flags_t   flags_q[$];
    logic [31:0] rng;
    int          errors = 0;
    int          checks = 0;
    int          issued = 0;
    int          cycles = 0;

    fp_adder UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_a      (op_a),
        .op_b      (op_b),
        .round_mode(round_mode),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .result    (result),
        .flags     (flags),
        .out_valid (out_valid)
    );

    bind fp_adder fp_adder_asserts u_asserts (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Signed integer with magnitude below 2^20
    task automatic draw_int(output int v);
        logic [31:0] r;
        rng = xorshift32(rng);
        r   = rng;
        v   = r[20] ? -int'(r[19:0]) : int'(r[19:0]);
    endtask

    function automatic fp_word_t int_to_fp(input int v);
        logic [31:0] mag;
        int          msb;
        mag = (v < 0) ? -v : v;
        msb = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        if (mag == 0) begin
            return '0;
        end
        return {v < 0, 8'(127 + msb), 23'(mag << (23 - msb))};
    endfunction

    // Exact cancellation keeps the sign of operand a
    function automatic fp_word_t expected_int_sum(input int a, input int b);
        if (a + b == 0) begin
            return {a < 0, 31'b0};
        end
        return int_to_fp(a + b);
    endfunction

    function automatic fp_flags_t flag_bit(input int idx);
        return fp_flags_t'(1) << idx;
    endfunction

    task automatic issue_op(input fp_word_t a, input fp_word_t b, input round_mode_t mode,
                            input fp_word_t exp_res, input fp_flags_t exp_flags);
        @(negedge clk);
        op_a       = a;
        op_b       = b;
        round_mode = mode;
        in_valid   = 1'b1;
        // in_ready only moves on a rising edge
        while (!in_ready) begin
            @(negedge clk);
        end
        res_q.push_back(exp_res);
        flags_q.push_back(exp_flags);
        issued++;
    endtask

    task automatic drain_and_report(input string name, input int n_ops, input int err_start);
        @(negedge clk);
        in_valid = 1'b0;
        while (res_q.size() != 0) begin
            @(negedge clk);
        end
        $display("%s: %0d ops, %0d errors", name, n_ops, errors - err_start);
    endtask

    // Outputs are register driven, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (res_q.size() == 0) begin
                $display("Result %h at time %0t arrived with no operation outstanding",
                         result, $time);
                errors++;
            end else begin
                checks += 2;
                assert (result === res_q[0]) else begin
                    $display("[FAIL] t=%0t result: expected %h, got %h",
                             $time, res_q[0], result);
                    errors++;
                end
                assert (flags === flags_q[0]) else begin
                    $display("[FAIL] t=%0t flags: expected %b, got %b",
                             $time, flags_q[0], flags);
                    errors++;
                end
                void'(res_q.pop_front());
                void'(flags_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d results still pending",
                     timeout_cycles, res_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int          a;
        int          b;
        int          err_start;
        int          total_fail;
        round_mode_t mode;
        fp_flags_t   invalid;
        rst_n      = 1'b0;
        op_a       = '0;
        op_b       = '0;
        round_mode = round_nearest_even;
        in_valid   = 1'b0;
        rng        = 32'd68;
        invalid    = flag_bit(flag_invalid);
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        $display("reset: idle state left to the bound assertions");

        for (int m = 0; m < 2; m++) begin
            mode      = (m == 0) ? round_nearest_even : round_to_zero;
            err_start = errors;
            for (int i = 0; i < n_rand; i++) begin
                draw_int(a);
                draw_int(b);
                issue_op(int_to_fp(a), int_to_fp(b), mode, expected_int_sum(a, b), '0);
            end
            drain_and_report(m == 0 ? "integer sums, nearest even" : "integer sums, toward zero",
                             n_rand, err_start);
        end

        err_start = errors;
        for (int i = 0; i < n_cancel; i++) begin
            draw_int(a);
            mode = round_mode_t'(i % 2);
            issue_op(int_to_fp(a), int_to_fp(-a), mode, expected_int_sum(a, -a), '0);
        end
        drain_and_report("x plus minus x", n_cancel, err_start);

        err_start = errors;
        issue_op(qnan_word, 32'h3F80_0000, round_nearest_even, qnan_word, invalid);
        issue_op(32'h4120_0000, 32'hFF81_2345, round_to_zero, qnan_word, invalid);
        issue_op(32'h7F80_0001, neg_inf, round_nearest_even, qnan_word, invalid);
        issue_op(pos_inf, neg_inf, round_nearest_even, qnan_word, invalid);
        issue_op(neg_inf, pos_inf, round_to_zero, qnan_word, invalid);
        issue_op(pos_inf, 32'hC0A0_0000, round_nearest_even, pos_inf, '0);
        issue_op(32'h40A0_0000, neg_inf, round_to_zero, neg_inf, '0);
        drain_and_report("NaN and infinity", 7, err_start);

        // (1 + 2^-23) + 2^-24 sits exactly halfway
        err_start = errors;
        issue_op(32'h3F80_0001, 32'h3380_0000, round_nearest_even, 32'h3F80_0002,
                 flag_bit(flag_inexact));
        issue_op(32'h3F80_0001, 32'h3380_0000, round_to_zero, 32'h3F80_0001,
                 flag_bit(flag_inexact));
        drain_and_report("rounding modes", 2, err_start);

        err_start = errors;
        issue_op(max_fin, max_fin, round_nearest_even, pos_inf,
                 flag_bit(flag_overflow) | flag_bit(flag_inexact));
        issue_op(max_fin | 32'h8000_0000, max_fin | 32'h8000_0000, round_nearest_even, neg_inf,
                 flag_bit(flag_overflow) | flag_bit(flag_inexact));
        drain_and_report("overflow", 2, err_start);

        total_fail = errors + UUT.u_asserts.fail_count;
        $display("checks: %0d compared, %0d failed, %0d assertion failures, %0d ops issued",
                 checks, errors, UUT.u_asserts.fail_count, issued);
        if (total_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/fp_adder.sv
`default_nettype none

module fp_adder
    import fp_format_pkg::*, fp_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  fp_word_t    op_a,
    input  fp_word_t    op_b,
    input  round_mode_t round_mode,
    input  logic        in_valid,
    output logic        in_ready,
    output fp_word_t    result,
    output fp_flags_t   flags,
    output logic        out_valid
);
    fp_stage_if #(.payload_t(align_item_t)) dec_if ();
    fp_stage_if #(.payload_t(norm_item_t))  exe_if ();
    fp_stage_if #(.payload_t(norm_item_t))  nrm_if ();

    fp_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_a      (op_a),
        .op_b      (op_b),
        .round_mode(round_mode),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .down      (dec_if.producer)
    );

    fp_execute u_execute (
        .clk  (clk),
        .rst_n(rst_n),
        .up   (dec_if.consumer),
        .down (exe_if.producer)
    );

    fp_normalize u_normalize (
        .clk  (clk),
        .rst_n(rst_n),
        .up   (exe_if.consumer),
        .down (nrm_if.producer)
    );

    fp_result u_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .up       (nrm_if.consumer),
        .result   (result),
        .flags    (flags),
        .out_valid(out_valid)
    );

endmodule

`default_nettype wire

//--- verilog/fp_decode.sv
`default_nettype none

module fp_decode
    import fp_format_pkg::*, fp_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  fp_word_t     op_a,
    input  fp_word_t     op_b,
    input  round_mode_t  round_mode,
    input  logic         in_valid,
    output logic         in_ready,
    fp_stage_if.producer down
);
    logic             sign_a;
    logic             sign_b;
    logic [exp_w-1:0] exp_a;
    logic [exp_w-1:0] exp_b;
    logic [man_w-1:0] frac_a;
    logic [man_w-1:0] frac_b;
    logic             nan_a;
    logic             nan_b;
    logic             inf_a;
    logic             inf_b;
    align_item_t      item;

    assign sign_a = op_a[sign_pos];
    assign sign_b = op_b[sign_pos];
    assign exp_a  = op_a[exp_lsb +: exp_w];
    assign exp_b  = op_b[exp_lsb +: exp_w];
    assign frac_a = op_a[man_w-1:0];
    assign frac_b = op_b[man_w-1:0];

    assign nan_a = (exp_a == exp_max) && (frac_a != '0);
    assign nan_b = (exp_b == exp_max) && (frac_b != '0);
    assign inf_a = (exp_a == exp_max) && (frac_a == '0);
    assign inf_b = (exp_b == exp_max) && (frac_b == '0);

    assign in_ready = down.ready;

    always_comb begin
        item         = '0;
        item.sign_a  = sign_a;
        item.sign_b  = sign_b;
        item.rmode   = round_mode;
        item.special = nan_a || nan_b || inf_a || inf_b;
        if (nan_a || nan_b || (inf_a && inf_b && (sign_a != sign_b))) begin
            item.special_word                = qnan_word;
            item.special_flags[flag_invalid] = 1'b1;
        end else if (inf_a) begin
            item.special_word = {sign_a, exp_max, {man_w{1'b0}}};
        end else if (inf_b) begin
            item.special_word = {sign_b, exp_max, {man_w{1'b0}}};
        end
        // Specials keep zero mantissas and finish early downstream
        if (!item.special) begin
            item.mant_a   = {exp_a != '0, frac_a, 3'b000};
            item.mant_b   = {exp_b != '0, frac_b, 3'b000};
            item.exp_diff = {1'b0, exp_a} - {1'b0, exp_b};
            item.exp      = item.exp_diff[exp_w] ? exp_b : exp_a;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            down.valid <= 1'b0;
        end else if (down.ready) begin
            down.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            down.data <= item;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fp_execute.sv
`default_nettype none

module fp_execute
    import fp_format_pkg::*, fp_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    fp_stage_if.consumer up,
    fp_stage_if.producer down
);
    logic [exp_w:0] shamt;
    align_item_t    aligned;
    align_item_t    al_q;
    logic           al_valid;
    logic           a_larger;
    norm_item_t     summed;

    assign up.ready = down.ready;

    // Smaller operand moves right by the exponent difference
    always_comb begin
        aligned = up.data;
        if (up.data.exp_diff[exp_w]) begin
            shamt          = -up.data.exp_diff;
            aligned.mant_a = up.data.mant_a >> shamt;
        end else begin
            shamt          = up.data.exp_diff;
            aligned.mant_b = up.data.mant_b >> shamt;
        end
    end

    always_comb begin
        a_larger             = al_q.mant_a >= al_q.mant_b;
        summed               = '0;
        summed.exp           = al_q.exp;
        summed.rmode         = al_q.rmode;
        summed.special       = al_q.special;
        summed.special_word  = al_q.special_word;
        summed.special_flags = al_q.special_flags;
        if (al_q.sign_a == al_q.sign_b) begin
            {summed.carry, summed.mant} = al_q.mant_a + al_q.mant_b;
            summed.sign                 = al_q.sign_a;
        end else if (a_larger) begin
            summed.mant = al_q.mant_a - al_q.mant_b;
            summed.sign = al_q.sign_a;
        end else begin
            summed.mant = al_q.mant_b - al_q.mant_a;
            summed.sign = al_q.sign_b;
        end
        // Exact cancellation
        if (!summed.carry && (summed.mant == '0)) begin
            summed.exp = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            al_valid   <= 1'b0;
            down.valid <= 1'b0;
        end else if (down.ready) begin
            al_valid   <= up.valid;
            down.valid <= al_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (down.ready) begin
            if (up.valid) begin
                al_q <= aligned;
            end
            if (al_valid) begin
                down.data <= summed;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

    // IEEE-754 single precision layout
    localparam int man_w  = 23;
    localparam int exp_w  = 8;
    localparam int word_w = 1 + exp_w + man_w;

    localparam int sign_pos = word_w - 1;
    localparam int exp_lsb  = man_w;

    // Hidden bit, fraction, then three rounding bits
    localparam int ext_w = man_w + 4;

    localparam logic [exp_w-1:0] exp_max = '1;

    // Canonical quiet NaN
    localparam logic [word_w-1:0] qnan_word = 32'h7FC0_0000;

    typedef logic [word_w-1:0] fp_word_t;

endpackage

`default_nettype wire

//--- verilog/fp_normalize.sv
`default_nettype none

module fp_normalize
    import fp_format_pkg::*, fp_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    fp_stage_if.consumer up,
    fp_stage_if.producer down
);
    logic       busy;
    logic       accept;
    logic       done;
    norm_item_t step;

    assign up.ready = !busy && (!down.valid || down.ready);
    assign accept   = up.valid && up.ready;

    always_comb begin
        if (busy) begin
            // One left shift per cycle
            step      = down.data;
            step.mant = down.data.mant << 1;
            step.exp  = down.data.exp - 1'b1;
            if (step.exp == '0) begin
                step.flags[flag_underflow] = 1'b1;
                step.flags[flag_inexact]   = 1'b1;
            end
        end else begin
            step = up.data;
            if (up.data.carry) begin
                step.mant  = {1'b1, up.data.mant[ext_w-1:1]};
                step.exp   = up.data.exp + 1'b1;
                step.carry = 1'b0;
                if (up.data.mant[0]) begin
                    step.flags[flag_inexact] = 1'b1;
                end
                if (step.exp == exp_max) begin
                    // Overflow to infinity
                    step.mant                 = '0;
                    step.flags[flag_overflow] = 1'b1;
                    step.flags[flag_inexact]  = 1'b1;
                end
            end
        end
        done = step.mant[ext_w-1] || (step.mant == '0) ||
               (step.exp == '0) || (step.exp == exp_max);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            down.valid <= 1'b0;
        end else if (accept || busy) begin
            busy       <= !done;
            down.valid <= done;
        end else if (down.ready) begin
            down.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept || busy) begin
            down.data <= step;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fp_pipe_pkg.sv
`default_nettype none

package fp_pipe_pkg;

    import fp_format_pkg::*;

    localparam int flag_overflow  = 0;
    localparam int flag_underflow = 1;
    localparam int flag_inexact   = 2;
    localparam int flag_invalid   = 3;

    typedef logic [3:0] fp_flags_t;

    typedef enum logic {
        round_nearest_even = 1'b0,
        round_to_zero      = 1'b1
    } round_mode_t;

    // exp_diff is exp_a minus exp_b in two's complement
    typedef struct packed {
        logic [ext_w-1:0] mant_a;
        logic [ext_w-1:0] mant_b;
        logic [exp_w-1:0] exp;
        logic [exp_w:0]   exp_diff;
        logic             sign_a;
        logic             sign_b;
        round_mode_t      rmode;
        logic             special;
        fp_word_t         special_word;
        fp_flags_t        special_flags;
    } align_item_t;

    // Same field order as the head of norm_item_t
    typedef struct packed {
        logic [ext_w-1:0] mant;
        logic [exp_w-1:0] exp;
        logic             carry;
        logic             sign;
        fp_flags_t        flags;
        logic             special;
        fp_word_t         special_word;
        fp_flags_t        special_flags;
    } round_item_t;

    typedef struct packed {
        logic [ext_w-1:0] mant;
        logic [exp_w-1:0] exp;
        logic             carry;
        logic             sign;
        fp_flags_t        flags;
        logic             special;
        fp_word_t         special_word;
        fp_flags_t        special_flags;
        round_mode_t      rmode;
    } norm_item_t;

endpackage

`default_nettype wire

//--- verilog/fp_result.sv
`default_nettype none

module fp_result
    import fp_format_pkg::*, fp_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    fp_stage_if.consumer up,
    output fp_word_t     result,
    output fp_flags_t    flags,
    output logic         out_valid
);
    fp_stage_if #(.payload_t(norm_item_t)) rnd_if ();
    fp_stage_if #(.payload_t(norm_item_t)) fin_if ();

    logic        lsb_bit;
    logic        rnd_bit;
    logic        sticky;
    logic        incr;
    round_item_t rnd;

    assign lsb_bit = up.data.mant[3];
    assign rnd_bit = up.data.mant[2];
    assign sticky  = |up.data.mant[1:0];

    always_comb begin
        case (up.data.rmode)
            round_nearest_even: incr = rnd_bit && (lsb_bit || sticky);
            round_to_zero:      incr = 1'b0;
            default:            incr = 1'b0;
        endcase
        {rnd.carry, rnd.mant}    = up.data.mant + {incr, 3'b000};
        rnd.exp                  = up.data.exp;
        rnd.sign                 = up.data.sign;
        rnd.flags                = up.data.flags;
        rnd.flags[flag_inexact]  = up.data.flags[flag_inexact] | rnd_bit | sticky;
        rnd.special              = up.data.special;
        rnd.special_word         = up.data.special_word;
        rnd.special_flags        = up.data.special_flags;
    end

    assign up.ready = rnd_if.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd_if.valid <= 1'b0;
        end else if (rnd_if.ready) begin
            rnd_if.valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && rnd_if.ready) begin
            rnd_if.data <= {rnd, up.data.rmode};
        end
    end

    // Rounding carry goes back through a normalizer
    fp_normalize u_renorm (
        .clk  (clk),
        .rst_n(rst_n),
        .up   (rnd_if.consumer),
        .down (fin_if.producer)
    );

    assign fin_if.ready = 1'b1;
    assign out_valid    = fin_if.valid;

    assign result = fin_if.data.special ? fin_if.data.special_word :
                    {fin_if.data.sign, fin_if.data.exp, fin_if.data.mant[ext_w-2 -: man_w]};
    assign flags  = fin_if.data.special ? fin_if.data.special_flags : fin_if.data.flags;

endmodule

`default_nettype wire

//--- verilog/fp_stage_if.sv
`default_nettype none

interface fp_stage_if #(
    parameter type payload_t = logic
);
    logic     valid;
    logic     ready;
    payload_t data;

    modport producer (
        output valid,
        output data,
        input  ready
    );

    modport consumer (
        input  valid,
        input  data,
        output ready
    );
endinterface

`default_nettype wire
